/* afifo_defs.svh */
/* Shared sizes for the CDC frame bridge
   Included by the package and by every RTL file that sizes a port or array */
`ifndef AFIFO_DEFS_SVH
`define AFIFO_DEFS_SVH

// ====================
// Payload
// ====================
`define DATA_WIDTH 16   // Data bits per FIFO word

// ====================
// FIFO geometry
// ====================
// Entry count, power of two and at least 4
// Gray quadrant decode needs two address bits
`define FIFO_DEPTH 8

// Frame word counter, wide enough for the longest frame
`define LEN_WIDTH 8

`endif

/* run.sh */
#!/bin/sh
# Build and run the frame bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tbBridge -o simBridge
out=$(./obj_dir/simBridge) || true
echo "$out"
if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* tb.f */
+incdir+.
verilog/bridgePkg.sv
verilog/grayPointer.sv
verilog/fifoMemory.sv
verilog/asyncFifo.sv
verilog/frameDrain.sv
verilog/cdcFrameBridge.sv
testbench/tbBridge.sv

/* testbench/tbBridge.sv */
/* Testbench for the CDC frame bridge with random frames, write gaps and stall windows
   Every forwarded word and frame report is checked against a reference model */
`timescale 1ns/1ps
`include "afifo_defs.svh"

module tbBridge;
    localparam int NUM_FRAMES = 24;
    localparam int WAIT_LIMIT = 200;  // Clock cycles per wait loop

    logic                  rclk = 1'b0;
    logic                  wclk = 1'b0;
    logic                  aempty;
    logic                  w;
    bridgePkg::fifoWord_t  wd;
    logic                  wok;
    logic                  stall;
    bridgePkg::fifoWord_t  outWord;
    logic                  outValid;
    bridgePkg::frameInfo_t frameReport;
    logic                  frameDone;

    bridgePkg::fifoWord_t expQ[$];        // Accepted writes not yet forwarded
    bridgePkg::fifoWord_t frameWords[$];  // Forwarded words of the open frame
    logic [15:0] wrLfsr = 16'd39;         // Write side stream
    logic [15:0] stLfsr = 16'd39;         // Stall window stream
    logic        stallPrev = 1'b0;        // Stall level one rclk cycle back
    logic        writesDone = 1'b0;
    int          framesSent = 0;
    int          framesChecked = 0;

    cdcFrameBridge dut (
        .rclk (rclk), .wclk (wclk), .aempty (aempty), .w (w), .wd (wd), .wok (wok),
        .stall (stall), .outWord (outWord), .outValid (outValid),
        .frameReport (frameReport), .frameDone (frameDone)
    );

    always #5 rclk = ~rclk;    // 10 ns
    always #3.5 wclk = ~wclk;  // 7 ns period unrelated to rclk

    // ====================
    // Helpers
    // ====================
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois form with taps 16 14 13 11
    endfunction

    task automatic takeBits(inout logic [15:0] st, input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            st = lfsrNext(st);
            val = (val << 1) | st[0];  // One step per bit
        end
    endtask

    // Expected report from the words of one frame
    function automatic bridgePkg::frameInfo_t refFrame(input bridgePkg::fifoWord_t words[$]);
        bridgePkg::frameInfo_t info;
        info.length   = `LEN_WIDTH'(words.size());
        info.checksum = '0;
        foreach (words[i]) info.checksum = info.checksum ^ words[i].data;
        return info;
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) failRun($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkWord(input bridgePkg::fifoWord_t got, input bridgePkg::fifoWord_t exp);
        if (got !== exp) failRun($sformatf("MISMATCH outWord got %h expected %h", got, exp));
    endtask

    task automatic checkFrame(input bridgePkg::frameInfo_t got,
                              input bridgePkg::frameInfo_t exp);
        if (got !== exp) failRun($sformatf("MISMATCH frameReport got %h expected %h", got, exp));
    endtask

    // Aligns to wclk and then waits for room
    task automatic waitWok(input string what);
        int cnt;
        cnt = 0;
        @(posedge wclk);
        #1;
        while (!wok) begin
            if (cnt == WAIT_LIMIT) failRun(what);
            @(posedge wclk);
            #1;
            cnt++;
        end
    endtask

    // Entered and left 1 ns after a wclk edge
    task automatic writeWord(input bridgePkg::fifoWord_t word);
        int cnt;
        cnt = 0;
        while (!wok) begin
            if (cnt == WAIT_LIMIT) failRun("timeout waiting for wok before a write");
            @(posedge wclk);
            #1;
            cnt++;
        end
        w  = 1'b1;
        wd = word;
        expQ.push_back(word);  // wok is high so the next edge takes it
        @(posedge wclk);
        #1;
        w = 1'b0;
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic fillUnderStall();
        int val;
        int i;
        bridgePkg::fifoWord_t word;
        @(posedge rclk);
        #1 stall = 1'b1;
        repeat (2) @(posedge rclk);
        @(posedge wclk);
        #1;
        for (i = 0; i < `FIFO_DEPTH; i++) begin
            checkFlag("wok", wok, 1'b1);  // Room until the last one
            takeBits(wrLfsr, `DATA_WIDTH, val);
            word.data = val[`DATA_WIDTH-1:0];
            word.last = (i == `FIFO_DEPTH - 1);
            writeWord(word);
        end
        framesSent++;
        checkFlag("wok", wok, 1'b0);  // Full right after the filling write
        repeat (10) begin
            @(posedge wclk);
            #1 checkFlag("wok", wok, 1'b0);
        end
        @(posedge rclk);
        #1 stall = 1'b0;
        waitWok("timeout waiting for wok after stall release");
    endtask

    task automatic writeFrames();
        int len;
        int val;
        int f;
        int i;
        bridgePkg::fifoWord_t word;
        for (f = 0; f < NUM_FRAMES; f++) begin
            takeBits(wrLfsr, 4, len);
            len = (f % 6 == 0) ? 1 : len % 12 + 1;  // Single word frames too
            for (i = 0; i < len; i++) begin
                takeBits(wrLfsr, `DATA_WIDTH, val);
                word.data = val[`DATA_WIDTH-1:0];
                word.last = (i == len - 1);
                writeWord(word);
                takeBits(wrLfsr, 2, val);  // Idle gap
                repeat (val) begin
                    @(posedge wclk);
                    #1;
                end
            end
            framesSent++;
        end
        writesDone = 1'b1;
    endtask

    // Short stall windows often land mid frame
    task automatic driveStall();
        int val;
        while (!writesDone) begin
            @(posedge rclk);
            #1;
            takeBits(stLfsr, 3, val);
            if (val == 0) begin
                takeBits(stLfsr, 4, val);
                stall = 1'b1;
                repeat (val + 1) @(posedge rclk);
                #1 stall = 1'b0;
            end
        end
    endtask

    // ====================
    // Checker
    // ====================
    always @(negedge rclk) begin : outputCheck
        bridgePkg::frameInfo_t expInfo;
        if (!aempty) begin
            if (outValid && stallPrev) failRun("outValid pulse after a stalled cycle");
            if (outValid) begin
                if (expQ.size() == 0) failRun("outValid with no written word pending");
                checkWord(outWord, expQ[0]);
                frameWords.push_back(expQ.pop_front());
            end
            if (frameDone) begin
                if (frameWords.size() == 0) failRun("frameDone with no words in the frame");
                if (!frameWords[frameWords.size() - 1].last) begin
                    failRun("frameDone before the last word of a frame");
                end
                expInfo = refFrame(frameWords);
                checkFrame(frameReport, expInfo);
                frameWords.delete();
                framesChecked++;
            end
        end
        stallPrev = stall;
    end

    initial begin : mainSeq
        int cnt;
        aempty = 1'b1;
        w      = 1'b0;
        wd     = '0;
        stall  = 1'b0;
        repeat (8) begin
            @(posedge rclk);
            #1;
            checkFlag("rok", dut.fifo.rok, 1'b0);
            checkFlag("wok", wok, 1'b0);
            checkFlag("outValid", outValid, 1'b0);
            checkFlag("frameDone", frameDone, 1'b0);
        end
        aempty = 1'b0;
        #1;
        checkFlag("rok", dut.fifo.rok, 1'b0);  // Release alone moves no output
        checkFlag("wok", wok, 1'b0);
        checkFlag("outValid", outValid, 1'b0);
        checkFlag("frameDone", frameDone, 1'b0);
        waitWok("timeout waiting for wok after reset");
        fillUnderStall();
        fork
            writeFrames();
            driveStall();
        join
        cnt = 0;
        while ((expQ.size() != 0 || framesChecked != framesSent) && cnt < WAIT_LIMIT) begin
            @(posedge rclk);
            cnt++;
        end
        if (expQ.size() == 0 && framesChecked == framesSent) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            failRun("timeout waiting for the last words and frame reports");
        end
    end

endmodule

/* verilog/asyncFifo.sv */
/* Async FIFO core with Gray pointers and a direction latch
   Flags set asynchronously and clear through two flops of their own clock */
`timescale 1ns/1ps
`include "afifo_defs.svh"

module asyncFifo (
    input  logic                 rclk,    // Read clock
    input  logic                 wclk,    // Write clock
    input  logic                 aempty,  // Async reset, both domains
    input  logic                 w,       // Write strobe
    input  bridgePkg::fifoWord_t wd,      // Write word
    output logic                 wok,     // Room for a word
    input  logic                 r,       // Pop strobe
    output bridgePkg::fifoWord_t rd,      // Head word
    output logic                 rok      // Word available
);
    localparam int AW = $clog2(`FIFO_DEPTH);
    localparam int N  = AW - 1;  // Pointer MSB

    logic [AW-1:0] wBin, wGray;  // Write pointer
    logic [AW-1:0] rBin, rGray;  // Read pointer
    logic          wInc, rInc;
    logic          dir;                     // 1 when heading toward full
    logic          dirSet, dirClr, dirReset;
    logic          emptyAsync, fullAsync;
    logic          emptySet, fullSet;
    logic          rEmpty, rEmpty2;         // Empty sync chain, rclk
    logic          wFull, wFull2;           // Full sync chain, wclk

    // ====================
    // Write side
    // ====================
    assign wInc = w & wok;  // Strobe while full is dropped

    grayPointer wPtr (
        .wclkOrRclk (wclk),
        .aempty     (aempty),
        .inc        (wInc),
        .binAddr    (wBin),
        .grayAddr   (wGray)
    );

    fifoMemory mem (
        .wclk  (wclk),
        .we    (wInc),
        .waddr (wBin),
        .raddr (rBin),
        .wdata (wd),
        .rdata (rd)
    );

    // Full rises at once, falls after two wclk edges
    always_ff @(posedge wclk or posedge fullSet) begin
        if (fullSet) begin
            {wFull, wFull2} <= 2'b11;
        end else begin
            {wFull, wFull2} <= {wFull2, 1'b0};
        end
    end

    assign wok = !wFull;

    // ====================
    // Read side
    // ====================
    assign rInc = r & rok;

    grayPointer rPtr (
        .wclkOrRclk (rclk),
        .aempty     (aempty),
        .inc        (rInc),
        .binAddr    (rBin),
        .grayAddr   (rGray)
    );

    // Mirror of the full chain
    always_ff @(posedge rclk or posedge emptySet) begin
        if (emptySet) begin
            {rEmpty, rEmpty2} <= 2'b11;
        end else begin
            {rEmpty, rEmpty2} <= {rEmpty2, 1'b0};
        end
    end

    assign rok = !rEmpty;

    // ====================
    // Async flag generation
    // ====================
    // Writer one quadrant behind reader means going full
    assign dirSet   = (wGray[N] != rGray[N-1]) & (wGray[N-1] == rGray[N]);
    assign dirClr   = (wGray[N] == rGray[N-1]) & (wGray[N-1] != rGray[N]);
    assign dirReset = dirClr | aempty;

    always_ff @(posedge dirSet or posedge dirReset) begin
        if (dirReset) begin
            dir <= 1'b0;
        end else begin
            dir <= 1'b1;
        end
    end

    assign emptyAsync = (wGray == rGray) & !dir;
    assign fullAsync  = (wGray == rGray) & dir;
    assign emptySet   = emptyAsync | aempty;
    assign fullSet    = fullAsync | aempty;  // wok held low through reset

    // Full implies data, so rok is up by the time the writer fills it
    wokOrRok: assert property (
        @(posedge wclk) disable iff (aempty)
        $past(wok) |-> (wok || rok)
    );

endmodule

/* verilog/bridgePkg.sv */
/* Types shared by the FIFO core, the drain FSM and the top level
   Referenced by scoped names, sizes come from the defines header */
`include "afifo_defs.svh"

package bridgePkg;

    // ====================
    // FIFO word
    // ====================
    // One entry as it is stored and forwarded
    typedef struct packed {
        logic                   last;  // Final word of a frame
        logic [`DATA_WIDTH-1:0] data;  // Payload
    } fifoWord_t;

    // ====================
    // Frame report
    // ====================
    typedef struct packed {
        logic [`LEN_WIDTH-1:0]  length;    // Words in the frame
        logic [`DATA_WIDTH-1:0] checksum;  // XOR over all data words
    } frameInfo_t;

    // Drain FSM states
    typedef enum logic [1:0] {
        sIdle,     // Waiting for the first word of a frame
        sCollect,  // Inside a frame
        sReport    // Report cycle, no pop
    } drainState_t;

endpackage

/* verilog/cdcFrameBridge.sv */
/* Top level of the frame bridge, write side on wclk, drain on rclk
   Joins the async FIFO core to the drain FSM */
`timescale 1ns/1ps

module cdcFrameBridge (
    input  logic                  rclk,         // Read domain clock
    input  logic                  wclk,         // Write domain clock
    input  logic                  aempty,       // Async reset, both domains
    input  logic                  w,            // Write strobe
    input  bridgePkg::fifoWord_t  wd,           // Write word
    output logic                  wok,          // FIFO not full
    input  logic                  stall,        // Hold the drain
    output bridgePkg::fifoWord_t  outWord,
    output logic                  outValid,
    output bridgePkg::frameInfo_t frameReport,
    output logic                  frameDone
);

    // ====================
    // Crossing wires
    // ====================
    bridgePkg::fifoWord_t rd;   // Head word
    logic                 rok;  // Head valid
    logic                 r;    // Pop from drain

    // Clock crossing
    asyncFifo fifo (
        .rclk   (rclk),
        .wclk   (wclk),
        .aempty (aempty),
        .w      (w),
        .wd     (wd),
        .wok    (wok),
        .r      (r),
        .rd     (rd),
        .rok    (rok)
    );

    // Read side framing
    frameDrain drain (
        .rclk        (rclk),
        .aempty      (aempty),
        .rd          (rd),
        .rok         (rok),
        .stall       (stall),
        .r           (r),
        .outWord     (outWord),
        .outValid    (outValid),
        .frameReport (frameReport),
        .frameDone   (frameDone)
    );

endmodule

/* verilog/fifoMemory.sv */
/* Storage array of the async FIFO
   Written on wclk, read combinationally at the read pointer */
`timescale 1ns/1ps
`include "afifo_defs.svh"

module fifoMemory (
    input  logic                           wclk,   // Write clock
    input  logic                           we,     // Write enable, already gated by wok
    input  logic [$clog2(`FIFO_DEPTH)-1:0] waddr,  // Write pointer, binary
    input  logic [$clog2(`FIFO_DEPTH)-1:0] raddr,  // Read pointer, binary
    input  bridgePkg::fifoWord_t           wdata,
    output bridgePkg::fifoWord_t           rdata
);

    // ====================
    // Array
    // ====================
    bridgePkg::fifoWord_t mem [`FIFO_DEPTH];

    // Single write port
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ====================
    // Read port
    // ====================
    // Head word shows while rok is high
    assign rdata = mem[raddr];

endmodule

/* verilog/frameDrain.sv */
/* Read-side drain FSM, pops FIFO words and forwards them one per cycle
   Reports frame length and XOR checksum in the cycle after each last word */
`timescale 1ns/1ps
`include "afifo_defs.svh"

module frameDrain (
    input  logic                  rclk,
    input  logic                  aempty,       // Async reset
    input  bridgePkg::fifoWord_t  rd,           // FIFO head word
    input  logic                  rok,          // Head word valid
    input  logic                  stall,        // Back-pressure level
    output logic                  r,            // Pop strobe
    output bridgePkg::fifoWord_t  outWord,
    output logic                  outValid,     // One-cycle pulse per word
    output bridgePkg::frameInfo_t frameReport,
    output logic                  frameDone     // One-cycle pulse per frame
);

    bridgePkg::drainState_t state;

    logic [`LEN_WIDTH-1:0]  lenAcc;   // Words so far in this frame
    logic [`DATA_WIDTH-1:0] sumAcc;   // Running XOR
    logic [`LEN_WIDTH-1:0]  lenNext;
    logic [`DATA_WIDTH-1:0] sumNext;

    // ====================
    // Pop and accumulate
    // ====================
    // No pop in the report cycle
    assign r = (state != bridgePkg::sReport) && rok && !stall;

    // Fresh frame starts from zero in sIdle
    assign lenNext = ((state == bridgePkg::sIdle) ? '0 : lenAcc) + 1'b1;
    assign sumNext = ((state == bridgePkg::sIdle) ? '0 : sumAcc) ^ rd.data;

    always_ff @(posedge rclk or posedge aempty) begin
        if (aempty) begin
            state     <= bridgePkg::sIdle;
            lenAcc    <= '0;
            sumAcc    <= '0;
            outValid  <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            outValid  <= r;        // Word leaves the cycle after its pop
            frameDone <= 1'b0;
            case (state)
                bridgePkg::sIdle, bridgePkg::sCollect: begin
                    if (r) begin
                        lenAcc <= lenNext;
                        sumAcc <= sumNext;
                        if (rd.last) begin
                            state     <= bridgePkg::sReport;
                            frameDone <= 1'b1;
                        end else begin
                            state <= bridgePkg::sCollect;
                        end
                    end
                end
                default: begin
                    state <= bridgePkg::sIdle;  // Report shown for one cycle
                end
            endcase
        end
    end

    // ====================
    // Payload registers
    // ====================
    always_ff @(posedge rclk) begin
        if (r) begin
            outWord <= rd;
        end
        if (r && rd.last) begin
            frameReport.length   <= lenNext;
            frameReport.checksum <= sumNext;
        end
    end

    // Report pulse tracks the FSM
    doneInReport: assert property (
        @(posedge rclk) disable iff (aempty)
        frameDone |-> (state == bridgePkg::sReport)
    );

    // Back-pressure honored
    noPopOnStall: assert property (
        @(posedge rclk) disable iff (aempty)
        stall |-> !r
    );

endmodule

/* verilog/grayPointer.sv */
/* Binary and Gray pointer pair for one side of the async FIFO
   One instance per clock domain, advanced on each accepted access */
`timescale 1ns/1ps
`include "afifo_defs.svh"

module grayPointer (
    input  logic                           wclkOrRclk,  // Clock of the owning domain
    input  logic                           aempty,      // Async reset
    input  logic                           inc,         // Step by one entry
    output logic [$clog2(`FIFO_DEPTH)-1:0] binAddr,     // Memory address
    output logic [$clog2(`FIFO_DEPTH)-1:0] grayAddr     // Compared across domains
);
    localparam int AW = $clog2(`FIFO_DEPTH);

    logic [AW-1:0] binNext;

    assign binNext = binAddr + 1'b1;  // Wraps at depth

    always_ff @(posedge wclkOrRclk or posedge aempty) begin
        if (aempty) begin
            binAddr  <= '0;
            grayAddr <= '0;
        end else if (inc) begin
            binAddr  <= binNext;
            grayAddr <= (binNext >> 1) ^ binNext;  // Gray code of new count
        end
    end

    // Other domain compares this code raw, so one bit per step
    grayOneBitStep: assert property (
        @(posedge wclkOrRclk) disable iff (aempty)
        inc |=> $onehot(grayAddr ^ $past(grayAddr))
    );

endmodule
